//--- src/timer_pkg.sv
package timer_pkg;

    // period counter width
    localparam int PERIOD_W = 24;

    // shorter periods get clamped up to this
    localparam int MIN_PERIOD = 2;

    // free-running timestamp width, wraps at 2^24
    localparam int TS_W = 24;

    // event sequence number width, wraps at 128
    localparam int SEQ_W = 7;

    // event buffer geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = 3;
    localparam int FIFO_LVL_W = 4;

    // one timer event, 31 bits
    // seq sits above stamp so the event register can use it directly
    typedef struct packed {
        logic [SEQ_W-1:0] seq;
        logic [TS_W-1:0]  stamp;
    } timer_event_t;

    // wishbone classic request from the host
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // register map, doubles as the bus opcode
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_PERIOD = 2'd1,
        REG_STATUS = 2'd2,
        REG_EVENT  = 2'd3
    } reg_addr_e;

endpackage

//--- src/preset_timer.sv
`timescale 1ns/1ps

module preset_timer
    import timer_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                enable_i,
    input  logic [PERIOD_W-1:0] period_i,
    input  logic                period_wr_i,
    output logic [PERIOD_W-1:0] period_o,
    output logic                tick_o
);

    localparam logic [PERIOD_W-1:0] MIN_P = PERIOD_W'(MIN_PERIOD);

    // period in use, always >= MIN_PERIOD
    logic [PERIOD_W-1:0] period_q;
    // counts period-1 down to 0
    logic [PERIOD_W-1:0] count_q;
    logic                tick_q;

    // clamped version of the incoming write value
    logic [PERIOD_W-1:0] period_clamped;

    // terminal count reached
    logic                at_end;

    always_comb begin
        if (period_i < MIN_P) begin
            period_clamped = MIN_P;
        end else begin
            period_clamped = period_i;
        end
    end

    assign at_end = (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            period_q <= MIN_P;
            count_q  <= MIN_P - 1'b1;
            tick_q   <= 1'b0;
        end else if (period_wr_i) begin
            // new period restarts the count from the top
            period_q <= period_clamped;
            count_q  <= period_clamped - 1'b1;
            tick_q   <= 1'b0;
        end else if (enable_i) begin
            // one tick every period enabled cycles
            tick_q <= at_end;
            if (at_end) begin
                count_q <= period_q - 1'b1;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end else begin
            // disabled, count holds
            tick_q <= 1'b0;
        end
    end

    assign period_o = period_q;
    assign tick_o   = tick_q;

endmodule

//--- src/tick_stamper.sv
`timescale 1ns/1ps

module tick_stamper
    import timer_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         tick_i,
    input  logic         full_i,
    output logic         push_o,
    output timer_event_t event_o,
    output logic         drop_o
);

    // free-running cycle count, runs even while the timer is off
    logic [TS_W-1:0]  cycle_q;
    // next sequence number to hand out
    logic [SEQ_W-1:0] seq_q;
    // record waiting to go out this cycle
    logic             pend_q;
    timer_event_t     event_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cycle_q <= '0;
            seq_q   <= '0;
            pend_q  <= 1'b0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
            pend_q  <= tick_i;
            // dropped ticks still consume a seq value
            if (tick_i) begin
                seq_q <= seq_q + 1'b1;
            end
        end
    end

    // record payload, stamp is the count seen at the tick
    always_ff @(posedge clk_i) begin
        if (tick_i) begin
            event_q.seq   <= seq_q;
            event_q.stamp <= cycle_q;
        end
    end

    // push one cycle after the tick unless the fifo has no room
    assign push_o  = pend_q & ~full_i;
    assign drop_o  = pend_q & full_i;
    assign event_o = event_q;

endmodule

//--- src/event_fifo.sv
`timescale 1ns/1ps

module event_fifo
    import timer_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  push_i,
    input  timer_event_t          event_i,
    input  logic                  pop_i,
    output timer_event_t          head_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic [FIFO_LVL_W-1:0] level_o
);

    timer_event_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_LVL_W-1:0] level_q;

    // qualified strobes, full push and empty pop are ignored
    logic do_push;
    logic do_pop;

    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == FIFO_LVL_W'(FIFO_DEPTH));
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // storage, no reset needed on the entries
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= event_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            // pointers wrap naturally at depth 8
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves level alone
            if (do_push && !do_pop) begin
                level_q <= level_q + 1'b1;
            end else if (do_pop && !do_push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    // first-word-fall-through head
    assign head_o  = mem[rd_ptr_q];
    assign level_o = level_q;

endmodule

//--- src/wb_timer_regs.sv
`timescale 1ns/1ps

module wb_timer_regs
    import timer_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  wb_req_t               wb_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  enable_o,
    output logic [PERIOD_W-1:0]   period_data_o,
    output logic                  period_wr_o,
    input  logic [PERIOD_W-1:0]   period_i,
    input  timer_event_t          head_i,
    input  logic                  empty_i,
    input  logic [FIFO_LVL_W-1:0] level_i,
    input  logic                  drop_i,
    output logic                  pop_o
);

    logic                ack_q;
    logic [31:0]         dat_q;
    logic                enable_q;
    logic                overflow_q;
    logic [PERIOD_W-1:0] period_data_q;
    logic                period_wr_q;

    // new bus cycle, only while ack is not already out
    logic      req;
    logic      wr;
    logic      rd;
    reg_addr_e addr;
    logic [31:0] rd_data;

    assign req  = wb_i.cyc & wb_i.stb & ~ack_q;
    assign wr   = req & wb_i.we;
    assign rd   = req & ~wb_i.we;
    assign addr = reg_addr_e'(wb_i.adr);

    // read mux
    always_comb begin
        case (addr)
            REG_CTRL:   rd_data = {31'd0, enable_q};
            REG_PERIOD: rd_data = {{(32 - PERIOD_W){1'b0}}, period_i};
            REG_STATUS: rd_data = {23'd0, overflow_q, {(8 - FIFO_LVL_W){1'b0}}, level_i};
            // valid bit on top, zero word when nothing is queued
            REG_EVENT:  rd_data = empty_i ? 32'd0 : {1'b1, head_i};
            default:    rd_data = 32'd0;
        endcase
    end

    // pop lands on the same edge that raises ack
    assign pop_o = rd & (addr == REG_EVENT) & ~empty_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q       <= 1'b0;
            enable_q    <= 1'b0;
            overflow_q  <= 1'b0;
            period_wr_q <= 1'b0;
        end else begin
            ack_q       <= req;
            period_wr_q <= wr & (addr == REG_PERIOD);
            if (wr && addr == REG_CTRL) begin
                enable_q <= wb_i.dat[0];
            end
            // a drop in the same cycle as the clear wins
            if (drop_i) begin
                overflow_q <= 1'b1;
            end else if (wr && addr == REG_STATUS) begin
                overflow_q <= 1'b0;
            end
        end
    end

    // payload side
    always_ff @(posedge clk_i) begin
        if (rd) begin
            dat_q <= rd_data;
        end
        if (wr && addr == REG_PERIOD) begin
            period_data_q <= wb_i.dat[PERIOD_W-1:0];
        end
    end

    assign wb_ack_o      = ack_q;
    assign wb_dat_o      = dat_q;
    assign enable_o      = enable_q;
    assign period_data_o = period_data_q;
    assign period_wr_o   = period_wr_q;

endmodule

//--- src/timer_top.sv
`timescale 1ns/1ps

module timer_top
    import timer_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  wb_req_t     wb_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    // register block to timer
    logic                  enable;
    logic [PERIOD_W-1:0]   period_data;
    logic                  period_wr;
    logic [PERIOD_W-1:0]   period;

    // timer to stamper
    logic                  tick;

    // stamper to fifo
    logic                  push;
    timer_event_t          event_rec;
    logic                  drop;
    logic                  full;

    // fifo to register block
    logic                  pop;
    timer_event_t          head;
    logic                  empty;
    logic [FIFO_LVL_W-1:0] level;

    preset_timer u_timer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .enable_i    (enable),
        .period_i    (period_data),
        .period_wr_i (period_wr),
        .period_o    (period),
        .tick_o      (tick)
    );

    tick_stamper u_stamper (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .tick_i  (tick),
        .full_i  (full),
        .push_o  (push),
        .event_o (event_rec),
        .drop_o  (drop)
    );

    event_fifo u_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (push),
        .event_i (event_rec),
        .pop_i   (pop),
        .head_o  (head),
        .empty_o (empty),
        .full_o  (full),
        .level_o (level)
    );

    wb_timer_regs u_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .wb_i          (wb_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .enable_o      (enable),
        .period_data_o (period_data),
        .period_wr_o   (period_wr),
        .period_i      (period),
        .head_i        (head),
        .empty_i       (empty),
        .level_i       (level),
        .drop_i        (drop),
        .pop_o         (pop)
    );

endmodule

//--- verif/timer_tb.sv
`timescale 1ns/1ps

module timer_tb
    import timer_pkg::*;
();

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 1;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 400;
    localparam int NUM_ROWS   = 6;

    // one stimulus row: period written, clamped readback, events to check
    typedef struct packed {
        logic [31:0] period;
        logic [31:0] readback;
        logic [31:0] count;
    } stim_row_t;

    stim_row_t rows [NUM_ROWS] = '{
        '{32'd0,  32'd2,  32'd6},
        '{32'd1,  32'd2,  32'd6},
        '{32'd2,  32'd2,  32'd6},
        '{32'd5,  32'd5,  32'd6},
        '{32'd17, 32'd17, 32'd4},
        '{32'd40, 32'd40, 32'd3}
    };

    logic        clk;
    logic        rst;
    wb_req_t     wb;
    logic [31:0] wb_dat;
    logic        wb_ack;

    int errors;
    int checks;

    // previous event, reference for the next interval
    logic [SEQ_W-1:0] last_seq;
    logic [TS_W-1:0]  last_stamp;

    timer_top UUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .wb_i     (wb),
        .wb_dat_o (wb_dat),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // closing summary, used at the normal end and on a timeout
    task automatic end_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // one classic cycle, entered and left just after a rising edge
    task automatic bus_access(input logic we, input reg_addr_e adr,
                              input logic [31:0] dat, output logic [31:0] rdata);
        int n;
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = we;
        wb.adr = adr;
        wb.dat = dat;
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (!wb_ack && n < ACK_LIMIT);
        rdata  = wb_dat;
        wb.cyc = 1'b0;
        wb.stb = 1'b0;
        wb.we  = 1'b0;
        if (!wb_ack) begin
            errors++;
            $display("no ack from register %0d after %0d cycles", adr, n);
            end_run();
        end
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        bus_access(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [31:0] rdata);
        bus_access(1'b0, adr, 32'd0, rdata);
    endtask

    // poll the event register until a valid record shows up
    task automatic pop_event(output logic [31:0] ev);
        int n;
        n = 0;
        wb_read(REG_EVENT, ev);
        while (!ev[31] && n < POLL_LIMIT) begin
            n++;
            wb_read(REG_EVENT, ev);
        end
        if (!ev[31]) begin
            errors++;
            $display("no event arrived after %0d polls", n);
            end_run();
        end
    endtask

    // timer must already be off, a late tick may still be in flight
    task automatic drain_fifo();
        logic [31:0] ev;
        int          n;
        idle(4);
        n = 0;
        wb_read(REG_EVENT, ev);
        while (ev[31] && n < FIFO_DEPTH + 4) begin
            n++;
            wb_read(REG_EVENT, ev);
        end
        if (ev[31]) begin
            errors++;
            $display("event FIFO still not empty after %0d reads", n);
            end_run();
        end
    endtask

    task automatic wait_level();
        logic [31:0] st;
        int          n;
        n = 0;
        wb_read(REG_STATUS, st);
        while (st[3:0] == 4'd0 && n < POLL_LIMIT) begin
            n++;
            wb_read(REG_STATUS, st);
        end
        if (st[3:0] == 4'd0) begin
            errors++;
            $display("FIFO level stayed at zero after %0d polls", n);
            end_run();
        end
    endtask

    task automatic take_ref(input logic [31:0] ev);
        last_seq   = ev[30:24];
        last_stamp = ev[23:0];
    endtask

    // next record is one period later, seq one up, both wrapping
    task automatic check_next(input logic [31:0] ev, input logic [31:0] period);
        logic [SEQ_W-1:0] exp_seq;
        logic [TS_W-1:0]  exp_stamp;
        exp_seq   = last_seq + SEQ_W'(1);
        exp_stamp = last_stamp + period[TS_W-1:0];
        check_val("event seq", 32'(ev[30:24]), 32'(exp_seq));
        check_val("event stamp", 32'(ev[23:0]), 32'(exp_stamp));
        take_ref(ev);
    endtask

    initial begin
        stim_row_t        row;
        logic [31:0]      rdata;
        logic [31:0]      ev;
        logic [SEQ_W-1:0] gap_seq;
        $timeformat(-9, 0, " ns", 0);
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        wb     = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // reset values, every address acks
        wb_read(REG_CTRL, rdata);
        check_val("ctrl", rdata, 32'd0);
        wb_read(REG_PERIOD, rdata);
        check_val("period", rdata, 32'(MIN_PERIOD));
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'd0);
        wb_read(REG_EVENT, rdata);
        check_val("event", rdata, 32'd0);
        // enable bit reads back as written
        wb_write(REG_CTRL, 32'd1);
        wb_read(REG_CTRL, rdata);
        check_val("ctrl", rdata, 32'd1);
        wb_write(REG_CTRL, 32'd0);
        wb_read(REG_CTRL, rdata);
        check_val("ctrl", rdata, 32'd0);

        // period table, readback and tick interval
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            wb_write(REG_CTRL, 32'd0);
            drain_fifo();
            wb_write(REG_PERIOD, row.period);
            wb_read(REG_PERIOD, rdata);
            check_val("period", rdata, row.readback);
            wb_write(REG_CTRL, 32'd1);
            // first record only sets the reference
            pop_event(ev);
            take_ref(ev);
            for (int k = 0; k < row.count; k++) begin
                pop_event(ev);
                check_next(ev, row.readback);
            end
        end

        // disabled timer produces nothing
        wb_write(REG_CTRL, 32'd0);
        drain_fifo();
        idle(5 * 40);
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'd0);
        wb_read(REG_EVENT, rdata);
        check_val("event", rdata, 32'd0);

        // overflow, 12 periods with no reads
        wb_write(REG_PERIOD, 32'd5);
        wb_write(REG_STATUS, 32'd0);
        wb_write(REG_CTRL, 32'd1);
        idle(12 * 5);
        wb_read(REG_STATUS, rdata);
        check_val("status level", 32'(rdata[3:0]), 32'd8);
        check_val("status overflow", 32'(rdata[8]), 32'd1);
        pop_event(ev);
        take_ref(ev);
        for (int k = 0; k < FIFO_DEPTH - 1; k++) begin
            pop_event(ev);
            check_next(ev, 32'd5);
        end
        // dropped ticks leave a hole in seq
        pop_event(ev);
        gap_seq = last_seq + SEQ_W'(1);
        check_val("seq gap", 32'(ev[30:24] != gap_seq), 32'd1);
        wb_write(REG_CTRL, 32'd0);
        drain_fifo();
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'h100);
        wb_write(REG_STATUS, 32'd0);
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'd0);

        // event register write leaves everything alone
        wb_write(REG_PERIOD, 32'd17);
        wb_write(REG_CTRL, 32'd1);
        wait_level();
        wb_write(REG_CTRL, 32'd0);
        idle(4);
        // exactly one record queued, overflow clear
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'd1);
        wb_write(REG_EVENT, 32'hFFFF_FFFF);
        wb_read(REG_STATUS, rdata);
        check_val("status", rdata, 32'd1);
        wb_read(REG_PERIOD, rdata);
        check_val("period", rdata, 32'd17);
        wb_read(REG_CTRL, rdata);
        check_val("ctrl", rdata, 32'd0);
        wb_read(REG_EVENT, rdata);
        check_val("event valid", 32'(rdata[31]), 32'd1);

        end_run();
    end

endmodule

//--- filelist.f
src/timer_pkg.sv
src/preset_timer.sv
src/tick_stamper.sv
src/event_fifo.sv
src/wb_timer_regs.sv
src/timer_top.sv
verif/timer_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
TOP       := timer_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTS PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
